// File: autotest_pkg.sv
// state encoding is visible on the debug port so the value order must stay fixed
`default_nettype none

package autotest_pkg;

  // debug view shows the raw state encoding
  typedef enum logic [4:0] {
    INIT          = 5'd0,
    SD_RESET      = 5'd1,
    SD_RESET_WAIT = 5'd2,
    IDLE          = 5'd3,
    RD_REQ        = 5'd4,
    RD_WAIT       = 5'd5,
    RD_TAKE       = 5'd6,
    RD_BYTE       = 5'd7,
    RD_BYTE_WAIT  = 5'd8,
    CHECK_SIG     = 5'd9,
    RUN           = 5'd10,
    CAPTURE       = 5'd11,
    COMPARE       = 5'd12,
    WR_REQ        = 5'd13,
    WR_WAIT       = 5'd14,
    WR_BYTE       = 5'd15,
    WR_BYTE_WAIT  = 5'd16,
    NEXT_BLOCK    = 5'd17,
    DONE          = 5'd18
  } seq_state_e;

  // byte 0 of a test block carries the top byte
  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

  localparam int SIG_BYTES = 4;

  // fits the 10-bit byte counter
  localparam int SD_BLOCK_BYTES = 512;

endpackage : autotest_pkg

`default_nettype wire

// File: load_if.sv
// one received SD byte per byte_we strobe, byte_idx is its offset in the 512-byte block
`timescale 1ns/1ps
`default_nettype none

interface load_if;

  logic       clear;
  logic       byte_we;
  logic [9:0] byte_idx;
  logic [7:0] byte_data;

  modport seq (
    output clear,
    output byte_we,
    output byte_idx,
    output byte_data
  );

  modport loader (
    input clear,
    input byte_we,
    input byte_idx,
    input byte_data
  );

endinterface : load_if

`default_nettype wire

// File: result_if.sv
// rd_data is combinational from rd_idx, all other result signals are registered
`timescale 1ns/1ps
`default_nettype none

interface result_if;

  logic        clear;
  logic        run;
  logic        capture;
  logic [3:0]  rd_idx;
  logic [7:0]  rd_data;
  logic        mismatch;
  logic [63:0] exec_cycles;

  modport seq (
    output clear,
    output run,
    output capture,
    output rd_idx,
    input  rd_data,
    input  mismatch,
    input  exec_cycles
  );

  modport result (
    input  clear,
    input  run,
    input  capture,
    input  rd_idx,
    output rd_data,
    output mismatch,
    output exec_cycles
  );

endinterface : result_if

`default_nettype wire

// File: vector_loader.sv
// BLOCK_BITS and KEY_BITS must be multiples of 8, fields follow the signature back to back
`timescale 1ns/1ps
`default_nettype none

module vector_loader #(
  parameter int BLOCK_BITS = 64,
  parameter int KEY_BITS   = 80
) (
  input  wire                   clk,
  input  wire                   rst,
  load_if.loader                ld,
  output logic                  sig_ok_o,
  output logic [BLOCK_BITS-1:0] block_o,
  output logic [KEY_BITS-1:0]   key_o,
  output logic                  encdec_o,
  output logic [BLOCK_BITS-1:0] expected_o
);

  import autotest_pkg::*;

  localparam int BLK_BYTES = BLOCK_BITS / 8;
  localparam int KEY_BYTES = KEY_BITS / 8;
  localparam int PT_OFF    = SIG_BYTES;
  localparam int KEY_OFF   = PT_OFF + BLK_BYTES;
  localparam int MODE_OFF  = KEY_OFF + KEY_BYTES;
  localparam int EXP_OFF   = MODE_OFF + 1;

  logic [8*SIG_BYTES-1:0] sig_q;

  always_ff @(posedge clk) begin
    if (rst || ld.clear) begin
      sig_q      <= '0;
      block_o    <= '0;
      key_o      <= '0;
      encdec_o   <= 1'b0;
      expected_o <= '0;
    end else if (ld.byte_we) begin
      // signature arrives top byte first
      for (int i = 0; i < SIG_BYTES; i++) begin
        if (ld.byte_idx == 10'(i)) begin
          sig_q[8*(SIG_BYTES-1-i) +: 8] <= ld.byte_data;
        end
      end
      // little-endian byte order for the payload fields
      for (int i = 0; i < BLK_BYTES; i++) begin
        if (ld.byte_idx == 10'(PT_OFF + i)) begin
          block_o[8*i +: 8] <= ld.byte_data;
        end
      end
      for (int i = 0; i < KEY_BYTES; i++) begin
        if (ld.byte_idx == 10'(KEY_OFF + i)) begin
          key_o[8*i +: 8] <= ld.byte_data;
        end
      end
      if (ld.byte_idx == 10'(MODE_OFF)) begin
        encdec_o <= ld.byte_data[0];
      end
      for (int i = 0; i < BLK_BYTES; i++) begin
        if (ld.byte_idx == 10'(EXP_OFF + i)) begin
          expected_o[8*i +: 8] <= ld.byte_data;
        end
      end
    end
  end

  assign sig_ok_o = (sig_q == SIGNATURE);

endmodule : vector_loader

`default_nettype wire

// File: result_unit.sv
// record is the captured output then the 64-bit cycle count, both least significant byte first
`timescale 1ns/1ps
`default_nettype none

module result_unit #(
  parameter int BLOCK_BITS = 64
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [BLOCK_BITS-1:0] uut_block_i,
  input  wire [BLOCK_BITS-1:0] expected_i,
  result_if.result             res
);

  localparam int REC_BITS = BLOCK_BITS + 64;

  logic [63:0]           timer_q;
  logic [BLOCK_BITS-1:0] out_q;
  logic [REC_BITS-1:0]   rec_shift;

  // counts every cycle the UUT runs
  always_ff @(posedge clk) begin
    if (rst || res.clear) begin
      timer_q <= '0;
    end else if (res.run) begin
      timer_q <= timer_q + 64'd1;
    end
  end

  // UUT output sampled once at the end of a run
  always_ff @(posedge clk) begin
    if (rst || res.clear) begin
      out_q <= '0;
    end else if (res.capture) begin
      out_q <= uut_block_i;
    end
  end

  assign res.mismatch    = (out_q != expected_i);
  assign res.exec_cycles = timer_q;

  // byte select for the SD write
  assign rec_shift   = {timer_q, out_q} >> {res.rd_idx, 3'b000};
  assign res.rd_data = rec_shift[7:0];

endmodule : result_unit

`default_nettype wire

// File: autotest_seq.sv
// SD host must raise busy for every request and drop it when done, record assumes BLOCK_BITS of 64
`timescale 1ns/1ps
`default_nettype none

module autotest_seq #(
  parameter int          BLOCK_BITS  = 64,
  parameter logic [31:0] START_BLOCK = 32'h0010_0000
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         sd_busy_i,
  input  wire  [7:0]  sd_data_out_i,
  output logic        sd_rst_o,
  output logic        sd_r_block_o,
  output logic        sd_r_byte_o,
  output logic        sd_w_block_o,
  output logic        sd_w_byte_o,
  output logic [31:0] sd_block_addr_o,
  output logic [7:0]  sd_data_in_o,
  output logic        uut_rst_o,
  input  wire         uut_end_i,
  input  wire         sig_ok_i,
  input  wire  [1:0]  debug_sel_i,
  output logic [31:0] debug_o,
  load_if.seq         ld,
  result_if.seq       res
);

  import autotest_pkg::*;

  // output bytes plus eight bytes of cycle count
  localparam logic [9:0] REC_BYTES = 10'(BLOCK_BITS / 8 + 8);
  localparam logic [9:0] LAST_BYTE = 10'(SD_BLOCK_BYTES - 1);

  seq_state_e  state_q;
  seq_state_e  state_d;
  logic [31:0] block_addr_q;
  logic [9:0]  byte_cnt_q;
  logic [31:0] err_cnt_q;
  logic        byte_last;

  assign byte_last = (byte_cnt_q == LAST_BYTE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= INIT;
      block_addr_q <= START_BLOCK;
      byte_cnt_q   <= '0;
      err_cnt_q    <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        INIT: begin
          block_addr_q <= START_BLOCK;
          err_cnt_q    <= '0;
        end
        IDLE: begin
          byte_cnt_q <= '0;
        end
        RD_TAKE: begin
          byte_cnt_q <= byte_last ? 10'd0 : byte_cnt_q + 10'd1;
        end
        COMPARE: begin
          if (res.mismatch) begin
            err_cnt_q <= err_cnt_q + 32'd1;
          end
        end
        WR_BYTE_WAIT: begin
          if (!sd_busy_i) begin
            byte_cnt_q <= byte_last ? 10'd0 : byte_cnt_q + 10'd1;
          end
        end
        // only after the write has finished
        NEXT_BLOCK: begin
          block_addr_q <= block_addr_q + 32'd1;
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    state_d      = state_q;
    sd_rst_o     = 1'b0;
    sd_r_block_o = 1'b0;
    sd_r_byte_o  = 1'b0;
    sd_w_block_o = 1'b0;
    sd_w_byte_o  = 1'b0;
    case (state_q)
      INIT: state_d = SD_RESET;
      SD_RESET: begin
        sd_rst_o = 1'b1;
        if (sd_busy_i) state_d = SD_RESET_WAIT;
      end
      SD_RESET_WAIT: begin
        if (!sd_busy_i) state_d = IDLE;
      end
      IDLE: begin
        if (!sd_busy_i) state_d = RD_REQ;
      end
      RD_REQ: begin
        sd_r_block_o = 1'b1;
        if (sd_busy_i) state_d = RD_WAIT;
      end
      RD_WAIT: begin
        sd_r_block_o = 1'b1;
        if (!sd_busy_i) state_d = RD_BYTE;
      end
      RD_BYTE: begin
        sd_r_block_o = 1'b1;
        sd_r_byte_o  = 1'b1;
        if (sd_busy_i) state_d = RD_BYTE_WAIT;
      end
      RD_BYTE_WAIT: begin
        sd_r_block_o = 1'b1;
        if (!sd_busy_i) state_d = RD_TAKE;
      end
      // data_out valid here, busy already low
      RD_TAKE: begin
        sd_r_block_o = 1'b1;
        state_d      = byte_last ? CHECK_SIG : RD_BYTE;
      end
      CHECK_SIG: state_d = sig_ok_i ? RUN : DONE;
      RUN: begin
        if (uut_end_i) state_d = CAPTURE;
      end
      CAPTURE: state_d = COMPARE;
      COMPARE: state_d = WR_REQ;
      WR_REQ: begin
        sd_w_block_o = 1'b1;
        if (sd_busy_i) state_d = WR_WAIT;
      end
      WR_WAIT: begin
        sd_w_block_o = 1'b1;
        if (!sd_busy_i) state_d = WR_BYTE;
      end
      WR_BYTE: begin
        sd_w_block_o = 1'b1;
        sd_w_byte_o  = 1'b1;
        if (sd_busy_i) state_d = WR_BYTE_WAIT;
      end
      WR_BYTE_WAIT: begin
        sd_w_block_o = 1'b1;
        if (!sd_busy_i) state_d = byte_last ? NEXT_BLOCK : WR_BYTE;
      end
      NEXT_BLOCK: state_d = IDLE;
      DONE: state_d = DONE;
      default: state_d = INIT;
    endcase
  end

  assign uut_rst_o       = (state_q != RUN);
  assign sd_block_addr_o = block_addr_q;

  // received bytes go straight to the loader
  assign ld.clear     = (state_q == IDLE);
  assign ld.byte_we   = (state_q == RD_TAKE);
  assign ld.byte_idx  = byte_cnt_q;
  assign ld.byte_data = sd_data_out_i;

  assign res.clear   = (state_q == IDLE);
  assign res.run     = (state_q == RUN);
  assign res.capture = (state_q == CAPTURE);
  assign res.rd_idx  = byte_cnt_q[3:0];

  // rest of the block is padding
  assign sd_data_in_o = (byte_cnt_q < REC_BYTES) ? res.rd_data : 8'hFF;

  always_comb begin
    case (debug_sel_i)
      2'd0:    debug_o = {block_addr_q[15:0], 11'd0, state_q};
      2'd1:    debug_o = err_cnt_q;
      2'd2:    debug_o = res.exec_cycles[31:0];
      default: debug_o = res.exec_cycles[63:32];
    endcase
  end

endmodule : autotest_seq

`default_nettype wire

// File: autotest_top.sv
// one test vector per SD block from START_BLOCK on, result record overwrites the same block
`timescale 1ns/1ps
`default_nettype none

module autotest_top #(
  parameter int          BLOCK_BITS  = 64,
  parameter int          KEY_BITS    = 80,
  parameter logic [31:0] START_BLOCK = 32'h0010_0000
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   sd_busy_i,
  input  wire  [7:0]            sd_data_out_i,
  output wire                   sd_rst_o,
  output wire                   sd_r_block_o,
  output wire                   sd_r_byte_o,
  output wire                   sd_w_block_o,
  output wire                   sd_w_byte_o,
  output wire  [31:0]           sd_block_addr_o,
  output wire  [7:0]            sd_data_in_o,
  output wire                   uut_rst_o,
  output wire  [BLOCK_BITS-1:0] uut_block_o,
  output wire  [KEY_BITS-1:0]   uut_key_o,
  output wire                   uut_encdec_o,
  input  wire  [BLOCK_BITS-1:0] uut_block_i,
  input  wire                   uut_end_i,
  input  wire  [1:0]            debug_sel_i,
  output wire  [31:0]           debug_o
);

  wire                  sig_ok;
  wire [BLOCK_BITS-1:0] expected;

  load_if   ld_if ();
  result_if res_if ();

  autotest_seq #(
    .BLOCK_BITS  (BLOCK_BITS),
    .START_BLOCK (START_BLOCK)
  ) seq_i (
    .clk             (clk),
    .rst             (rst),
    .sd_busy_i       (sd_busy_i),
    .sd_data_out_i   (sd_data_out_i),
    .sd_rst_o        (sd_rst_o),
    .sd_r_block_o    (sd_r_block_o),
    .sd_r_byte_o     (sd_r_byte_o),
    .sd_w_block_o    (sd_w_block_o),
    .sd_w_byte_o     (sd_w_byte_o),
    .sd_block_addr_o (sd_block_addr_o),
    .sd_data_in_o    (sd_data_in_o),
    .uut_rst_o       (uut_rst_o),
    .uut_end_i       (uut_end_i),
    .sig_ok_i        (sig_ok),
    .debug_sel_i     (debug_sel_i),
    .debug_o         (debug_o),
    .ld              (ld_if.seq),
    .res             (res_if.seq)
  );

  vector_loader #(
    .BLOCK_BITS (BLOCK_BITS),
    .KEY_BITS   (KEY_BITS)
  ) loader_i (
    .clk        (clk),
    .rst        (rst),
    .ld         (ld_if.loader),
    .sig_ok_o   (sig_ok),
    .block_o    (uut_block_o),
    .key_o      (uut_key_o),
    .encdec_o   (uut_encdec_o),
    .expected_o (expected)
  );

  result_unit #(
    .BLOCK_BITS (BLOCK_BITS)
  ) result_i (
    .clk         (clk),
    .rst         (rst),
    .uut_block_i (uut_block_i),
    .expected_i  (expected),
    .res         (res_if.result)
  );

endmodule : autotest_top

`default_nettype wire

// File: tb_sd_model.sv
// behavioural SD host for blocks BASE_BLOCK to BASE_BLOCK+3 only, byte busy lasts 1 to 3 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_sd_model #(
  parameter logic [31:0] BASE_BLOCK = 32'h0010_0000
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         sd_rst_i,
  input  wire         r_block_i,
  input  wire         r_byte_i,
  input  wire         w_block_i,
  input  wire         w_byte_i,
  input  wire  [31:0] block_addr_i,
  input  wire  [7:0]  data_in_i,
  output logic        busy_o,
  output logic [7:0]  data_out_o
);

  logic [7:0]  mem [0:2047];
  logic [2:0]  wait_q;
  logic [1:0]  lat_q;
  logic        blk_open_q;
  logic [8:0]  ptr_q;
  logic [31:0] blk;
  logic [10:0] addr;

  assign blk  = block_addr_i - BASE_BLOCK;
  assign addr = {blk[1:0], ptr_q};

  initial begin
    busy_o     = 1'b0;
    data_out_o = 8'h00;
  end

  always @(posedge clk) begin
    if (rst) begin
      busy_o     <= 1'b0;
      wait_q     <= 3'd0;
      lat_q      <= 2'd0;
      blk_open_q <= 1'b0;
      ptr_q      <= 9'd0;
    end else if (busy_o) begin
      if (wait_q == 3'd0) begin
        busy_o <= 1'b0;
      end else begin
        wait_q <= wait_q - 3'd1;
      end
    end else if (sd_rst_i) begin
      busy_o     <= 1'b1;
      wait_q     <= 3'd6;
      blk_open_q <= 1'b0;
    end else if ((r_block_i || w_block_i) && !blk_open_q) begin
      // block setup restarts the byte pointer
      busy_o     <= 1'b1;
      wait_q     <= 3'd4;
      blk_open_q <= 1'b1;
      ptr_q      <= 9'd0;
    end else if (r_byte_i || w_byte_i) begin
      if (r_byte_i) begin
        data_out_o <= mem[addr];
      end else begin
        mem[addr] <= data_in_i;
      end
      ptr_q  <= ptr_q + 9'd1;
      busy_o <= 1'b1;
      wait_q <= {1'b0, lat_q};
      lat_q  <= (lat_q == 2'd2) ? 2'd0 : lat_q + 2'd1;
    end else if (!r_block_i && !w_block_i) begin
      blk_open_q <= 1'b0;
    end
  end

endmodule : tb_sd_model

`default_nettype wire

// File: tb_autotest.sv
// UUT is modelled as plaintext xor low 64 key bits, four SD blocks, block 3 carries a bad signature
`timescale 1ns/1ps
`default_nettype none

module tb_autotest;

  localparam logic [31:0] START_BLOCK = 32'h0010_0000;
  localparam int NUM_BLOCKS = 4;
  // blocks x bytes x handshake cycles x margin
  localparam int WATCHDOG_CYCLES = 4 * 1100 * 4 * 2;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [1:0]  debug_sel = 2'd0;
  logic [63:0] uut_out = '0;
  logic        uut_end = 1'b0;
  wire         sd_busy;
  wire  [7:0]  sd_data_out;
  wire         sd_rst;
  wire         sd_r_block;
  wire         sd_r_byte;
  wire         sd_w_block;
  wire         sd_w_byte;
  wire  [31:0] sd_addr;
  wire  [7:0]  sd_data_in;
  wire         uut_rst;
  wire  [63:0] uut_pt;
  wire  [79:0] uut_key;
  wire         uut_encdec;
  wire  [31:0] debug;

  logic [63:0] pt_v     [NUM_BLOCKS];
  logic [79:0] key_v    [NUM_BLOCKS];
  logic        mode_v   [NUM_BLOCKS];
  logic [63:0] cycles_v [NUM_BLOCKS];
  logic [31:0] rng = 32'h3f4f;
  logic [5:0]  end_delay = 6'd3;
  logic [31:0] run_cnt = '0;
  logic        uut_rst_q = 1'b1;
  logic        done_seen = 1'b0;
  logic [1:0]  cur;
  int          errors = 0;
  int          failed = 0;

  assign cur = 2'(sd_addr - START_BLOCK);

  always #4 clk = ~clk;

  autotest_top #(.BLOCK_BITS(64), .KEY_BITS(80), .START_BLOCK(START_BLOCK)) autotest_top_i (
    .clk(clk), .rst(rst), .sd_busy_i(sd_busy), .sd_data_out_i(sd_data_out),
    .sd_rst_o(sd_rst), .sd_r_block_o(sd_r_block), .sd_r_byte_o(sd_r_byte),
    .sd_w_block_o(sd_w_block), .sd_w_byte_o(sd_w_byte), .sd_block_addr_o(sd_addr),
    .sd_data_in_o(sd_data_in), .uut_rst_o(uut_rst), .uut_block_o(uut_pt),
    .uut_key_o(uut_key), .uut_encdec_o(uut_encdec), .uut_block_i(uut_out),
    .uut_end_i(uut_end), .debug_sel_i(debug_sel), .debug_o(debug)
  );

  tb_sd_model #(.BASE_BLOCK(START_BLOCK)) sd_i (
    .clk(clk), .rst(rst), .sd_rst_i(sd_rst), .r_block_i(sd_r_block), .r_byte_i(sd_r_byte),
    .w_block_i(sd_w_block), .w_byte_i(sd_w_byte), .block_addr_i(sd_addr),
    .data_in_i(sd_data_in), .busy_o(sd_busy), .data_out_o(sd_data_out)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [63:0] cipher_model(input logic [63:0] pt, input logic [79:0] key,
                                               input logic enc);
    logic [63:0] x;
    x = pt ^ key[63:0];
    return enc ? x : ~x;
  endfunction

  // end rises end_delay cycles after the UUT reset falls
  always @(posedge clk) begin
    if (rst) begin
      run_cnt   <= '0;
      uut_end   <= 1'b0;
      uut_rst_q <= 1'b1;
    end else begin
      uut_rst_q <= uut_rst;
      uut_out   <= cipher_model(uut_pt, uut_key, uut_encdec);
      if (!uut_rst) begin
        run_cnt <= uut_rst_q ? 32'd1 : run_cnt + 32'd1;
        if ((uut_rst_q ? 32'd1 : run_cnt + 32'd1) == {26'd0, end_delay}) begin
          uut_end <= 1'b1;
        end
      end else begin
        uut_end <= 1'b0;
        if (!uut_rst_q) begin
          cycles_v[cur] <= {32'd0, run_cnt};
          rng           <= xorshift(rng);
          end_delay     <= 6'(32'd3 + xorshift(rng) % 32'd38);
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && !uut_rst) begin
      assert (uut_pt == pt_v[cur] && uut_key == key_v[cur] && uut_encdec == mode_v[cur])
      else begin
        errors++;
        $display("ERR %0t: UUT inputs %h %h %b differ from block %0d", $time, uut_pt, uut_key,
                 uut_encdec, cur);
      end
    end
  end

  // address moves by one, only between block transfers
  assert property (@(posedge clk) disable iff (rst)
      (sd_addr != $past(sd_addr)) |->
        (sd_addr == $past(sd_addr) + 32'd1) && !$past(sd_r_block) && !$past(sd_w_block))
    else begin
      errors++;
      $display("ERR %0t: block address changed to %h inside a transfer", $time, sd_addr);
    end

  assert property (@(posedge clk) disable iff (rst)
      done_seen |-> !(sd_rst || sd_r_block || sd_w_block))
    else begin
      errors++;
      $display("ERR %0t: SD request issued after the harness stopped", $time);
    end

  task automatic build_block(input int b, input logic wrong, input logic bad_sig);
    logic [63:0] exp_v;
    logic [31:0] hi;
    logic [31:0] mid;
    int base;
    base = b * 512;
    for (int a = base; a < base + 512; a++) begin
      sd_i.mem[11'(a)] = 8'(a ^ (a >> 8));
    end
    rng = xorshift(rng);
    hi = rng;
    rng = xorshift(rng);
    pt_v[2'(b)] = {hi, rng};
    rng = xorshift(rng);
    hi = rng;
    rng = xorshift(rng);
    mid = rng;
    rng = xorshift(rng);
    key_v[2'(b)] = {hi[15:0], mid, rng};
    mode_v[2'(b)] = (b % 2 == 0);
    exp_v = cipher_model(pt_v[2'(b)], key_v[2'(b)], mode_v[2'(b)]) ^ {63'd0, wrong};
    sd_i.mem[11'(base)]     = 8'hAA;
    sd_i.mem[11'(base + 1)] = 8'hBB;
    sd_i.mem[11'(base + 2)] = 8'hCC;
    sd_i.mem[11'(base + 3)] = bad_sig ? 8'h00 : 8'hDD;
    for (int i = 0; i < 8; i++) begin
      sd_i.mem[11'(base + 4 + i)]  = 8'(pt_v[2'(b)] >> (8 * i));
      sd_i.mem[11'(base + 23 + i)] = 8'(exp_v >> (8 * i));
    end
    for (int i = 0; i < 10; i++) begin
      sd_i.mem[11'(base + 12 + i)] = 8'(key_v[2'(b)] >> (8 * i));
    end
    // only bit 0 of the mode byte counts
    sd_i.mem[11'(base + 22)] = {7'h2a, mode_v[2'(b)]};
  endtask

  task automatic check_record(input int b);
    logic [63:0] out_v;
    logic [7:0]  want;
    logic [7:0]  got;
    out_v = cipher_model(pt_v[2'(b)], key_v[2'(b)], mode_v[2'(b)]);
    for (int i = 0; i < 512; i++) begin
      if (i < 8) begin
        want = 8'(out_v >> (8 * i));
      end else if (i < 16) begin
        want = 8'(cycles_v[2'(b)] >> (8 * (i - 8)));
      end else begin
        want = 8'hFF;
      end
      got = sd_i.mem[11'(b * 512 + i)];
      assert (got == want) else begin
        errors++;
        $display("ERR %0t: block %0d byte %0d is %h, expected %h", $time, b, i, got, want);
      end
    end
  endtask

  task automatic check_debug_view(input logic [1:0] sel, input logic [31:0] want);
    @(posedge clk);
    debug_sel <= sel;
    @(negedge clk);
    assert (debug == want) else begin
      errors++;
      $display("ERR %0t: debug view %0d is %h, expected %h", $time, sel, debug, want);
    end
    @(posedge clk);
    debug_sel <= 2'd0;
  endtask

  task automatic report_test(input int b, input int errs_before);
    if (errors == errs_before) begin
      $display("test block %0d passed", b);
    end else begin
      failed++;
      $display("test block %0d failed with %0d errors", b, errors - errs_before);
    end
  endtask

  initial begin
    int errs_before;
    int n_wrong;
    n_wrong = 0;
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      build_block(b, b == 1, b == 3);
    end
    rng = xorshift(rng);
    end_delay = 6'(32'd3 + rng % 32'd38);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (sd_addr == START_BLOCK) else begin
      errors++;
      $display("ERR %0t: start address %h", $time, sd_addr);
    end
    for (int b = 0; b < 3; b++) begin
      errs_before = errors;
      // cycle count holds still while the record is written
      while (!sd_w_block) begin
        @(negedge clk);
      end
      check_debug_view(2'd2, cycles_v[2'(b)][31:0]);
      check_debug_view(2'd3, cycles_v[2'(b)][63:32]);
      while (sd_addr != START_BLOCK + 32'(b) + 32'd1) begin
        @(negedge clk);
      end
      if (b == 1) begin
        n_wrong++;
      end
      check_record(b);
      check_debug_view(2'd1, 32'(n_wrong));
      report_test(b, errs_before);
    end
    errs_before = errors;
    while (debug[4:0] != 5'd18) begin
      @(negedge clk);
    end
    done_seen = 1'b1;
    repeat (200) @(negedge clk);
    assert (debug == {16'(START_BLOCK + 32'd3), 11'd0, 5'd18} &&
            sd_addr == START_BLOCK + 32'd3) else begin
      errors++;
      $display("ERR %0t: debug %h, address %h after bad signature", $time, debug, sd_addr);
    end
    report_test(3, errs_before);
    $display("tests %0d, failed %0d, errors %0d", NUM_BLOCKS, failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the harness never finished", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule : tb_autotest

`default_nettype wire

// File: files.f
autotest_pkg.sv
load_if.sv
result_if.sv
vector_loader.sv
result_unit.sv
autotest_seq.sv
autotest_top.sv
tb_sd_model.sv
tb_autotest.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_autotest
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
